// File: Bender.yml
package:
  name: dma_tcdm_xbar

sources:
  - include_dirs:
      - design
    files:
      - design/tcdm_pkg.sv
      - design/dma_port_merge.sv
      - design/tcdm_bank_arbiter.sv
      - design/tcdm_resp_route.sv
      - design/dma_tcdm_xbar.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tcdm_bank_model.sv
      - test/tb_dma_tcdm_xbar.sv

// File: design/dma_port_merge.sv
// Purely combinational; add and wen of a pair come from the even port, so both ports must agree on them
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

module dma_port_merge
(
   // Narrow DMA ports
   input  tcdm_pkg::dma_req_t  [`TCDM_NB_DMA_PORTS-1:0] dma_req_i,
   input  logic                [`TCDM_NB_DMA_PORTS-1:0] dma_valid_req_i,

   // Wide channels towards the bank arbiters
   output tcdm_pkg::chan_req_t [`TCDM_NB_CHAN-1:0]      chan_req_o,
   output tcdm_pkg::chan_mask_t                         chan_valid_o
);

   import tcdm_pkg::*;

   // **************************************************************************
   // Port pairing
   // **************************************************************************

   // Ports 2c and 2c+1 feed channel c
   for (genvar c = 0; c < `TCDM_NB_CHAN; c++)
   begin : g_chan
      dma_req_t  even_req;
      dma_req_t  odd_req;
      chan_req_t chan_req;

      assign even_req = dma_req_i[2*c];
      assign odd_req  = dma_req_i[2*c+1];

      // Either port of the pair raises the channel request
      assign chan_valid_o[c] = dma_valid_req_i[2*c] | dma_valid_req_i[2*c+1];

      always_comb
      begin
         // Address split done once here
         // Byte offset bits are dropped
         chan_req.bank = even_req.add[`TCDM_BANK_LSB +: $clog2(`TCDM_NB_BANKS)];
         chan_req.row  = even_req.add[`TCDM_BANK_LSB-1 -: `TCDM_ROW_WIDTH];

         // Even port decides read or write
         chan_req.wen  = even_req.wen;

         // Odd port goes to the upper lane
         chan_req.wdata.lanes[0] = even_req.wdata;
         chan_req.wdata.lanes[1] = odd_req.wdata;

         // Byte enables follow the same lane order
         chan_req.be = {odd_req.be, even_req.be};
      end

      assign chan_req_o[c] = chan_req;
   end

endmodule

`default_nettype wire

// File: design/dma_tcdm_xbar.sv
// Paired DMA ports share add and wen; the bank side expects one-cycle read latency on every port
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

module dma_tcdm_xbar
(
   input  logic                                                 clk_i,
   input  logic                                                 reset_i,

   // **************************************************************************
   // Narrow DMA ports
   // **************************************************************************

   // Request, held until granted
   input  tcdm_pkg::dma_req_t [`TCDM_NB_DMA_PORTS-1:0]          dma_req_i,
   input  logic               [`TCDM_NB_DMA_PORTS-1:0]          dma_valid_req_i,

   // Grant in the request cycle, response one cycle later
   output logic [`TCDM_NB_DMA_PORTS-1:0]                        dma_gnt_o,
   output logic [`TCDM_NB_DMA_PORTS-1:0]                        dma_r_valid_o,
   output logic [`TCDM_NB_DMA_PORTS-1:0][`TCDM_DATA_WIDTH-1:0]  dma_r_rdata_o,

   // **************************************************************************
   // SRAM bank ports
   // **************************************************************************

   output tcdm_pkg::bank_req_t  [`TCDM_NB_BANKS-1:0]            bank_req_o,
   output logic                 [`TCDM_NB_BANKS-1:0]            bank_valid_o,
   input  tcdm_pkg::tcdm_word_u [`TCDM_NB_BANKS-1:0]            bank_rdata_i
);

   import tcdm_pkg::*;

   // Wide channel bus
   chan_req_t [`TCDM_NB_CHAN-1:0]  chan_req;
   chan_mask_t                     chan_valid;

   // Grant mask of every bank
   chan_mask_t [`TCDM_NB_BANKS-1:0] bank_gnt;

   // **************************************************************************
   // Input side
   // **************************************************************************

   dma_port_merge port_merge_inst
   (
      .dma_req_i       ( dma_req_i       ),
      .dma_valid_req_i ( dma_valid_req_i ),
      .chan_req_o      ( chan_req        ),
      .chan_valid_o    ( chan_valid      )
   );

   // **************************************************************************
   // Crossbar
   // **************************************************************************

   // One arbiter per bank, each sees every channel
   for (genvar b = 0; b < `TCDM_NB_BANKS; b++)
   begin : g_bank
      tcdm_bank_arbiter
      #(
         .BANK_ID      ( b               )
      )
      bank_arbiter_inst
      (
         .clk_i        ( clk_i           ),
         .reset_i      ( reset_i         ),
         .chan_req_i   ( chan_req        ),
         .chan_valid_i ( chan_valid      ),
         .gnt_o        ( bank_gnt[b]     ),
         .bank_req_o   ( bank_req_o[b]   ),
         .bank_valid_o ( bank_valid_o[b] )
      );
   end

   // **************************************************************************
   // Output side
   // **************************************************************************

   tcdm_resp_route resp_route_inst
   (
      .clk_i         ( clk_i         ),
      .reset_i       ( reset_i       ),
      .bank_gnt_i    ( bank_gnt      ),
      .bank_rdata_i  ( bank_rdata_i  ),
      .dma_gnt_o     ( dma_gnt_o     ),
      .dma_r_valid_o ( dma_r_valid_o ),
      .dma_r_rdata_o ( dma_r_rdata_o )
   );

endmodule

`default_nettype wire

// File: design/tcdm_bank_arbiter.sv
// Grant is combinational in the request cycle; a held request wins within NB_CHAN cycles
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

module tcdm_bank_arbiter
#(
   parameter int unsigned BANK_ID = 0
)
(
   input  logic                                    clk_i,
   input  logic                                    reset_i,

   // All wide channels
   input  tcdm_pkg::chan_req_t [`TCDM_NB_CHAN-1:0] chan_req_i,
   input  tcdm_pkg::chan_mask_t                    chan_valid_i,
   output tcdm_pkg::chan_mask_t                    gnt_o,

   // SRAM bank port
   output tcdm_pkg::bank_req_t                     bank_req_o,
   output logic                                    bank_valid_o
);

   import tcdm_pkg::*;

   localparam int unsigned BANK_W = $clog2(`TCDM_NB_BANKS);
   localparam int unsigned PTR_W  = (`TCDM_NB_CHAN > 1) ? $clog2(`TCDM_NB_CHAN) : 1;
   localparam logic [BANK_W-1:0] BANK_SEL = BANK_W'(BANK_ID);

   // Channel with highest priority in this cycle
   logic [PTR_W-1:0] rr_ptr_q;

   chan_mask_t       hit;
   logic             win_found;
   logic [PTR_W-1:0] win_idx;

   // **************************************************************************
   // Request selection
   // **************************************************************************

   // Channels that want this bank
   always_comb
   begin
      for (int c = 0; c < `TCDM_NB_CHAN; c++)
      begin
         hit[c] = chan_valid_i[c] && (chan_req_i[c].bank == BANK_SEL);
      end
   end

   // Search starts at the pointer and wraps around
   always_comb
   begin
      int unsigned idx;
      win_found = 1'b0;
      win_idx   = rr_ptr_q;
      for (int k = 0; k < `TCDM_NB_CHAN; k++)
      begin
         idx = (int'(rr_ptr_q) + k) % `TCDM_NB_CHAN;
         if (!win_found && hit[idx])
         begin
            win_found = 1'b1;
            win_idx   = PTR_W'(idx);
         end
      end
   end

   // One-hot grant back to the winner
   always_comb
   begin
      gnt_o = '0;
      if (win_found)
      begin
         gnt_o[win_idx] = 1'b1;
      end
   end

   // **************************************************************************
   // Bank port
   // **************************************************************************

   // Payload follows win_idx even when idle, only bank_valid_o matters then
   assign bank_valid_o     = win_found;
   assign bank_req_o.row   = chan_req_i[win_idx].row;
   assign bank_req_o.wen   = chan_req_i[win_idx].wen;
   assign bank_req_o.wdata = chan_req_i[win_idx].wdata;
   assign bank_req_o.be    = chan_req_i[win_idx].be;

   // Winner drops to lowest priority after its grant
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rr_ptr_q <= '0;
      end
      else if (win_found)
      begin
         if (int'(win_idx) == `TCDM_NB_CHAN - 1)
            rr_ptr_q <= '0;
         else
            rr_ptr_q <= win_idx + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: design/tcdm_pkg.sv
// Types only; widths come from tcdm_settings.svh and wen is passed to the banks unchanged
`default_nettype none

`include "tcdm_settings.svh"

package tcdm_pkg;

   // **************************************************************************
   // Narrow side
   // **************************************************************************

   // One 32-bit DMA port request
   typedef struct packed {
      logic [`TCDM_ADDR_WIDTH-1:0]   add;
      logic                          wen;
      logic [`TCDM_DATA_WIDTH-1:0]   wdata;
      logic [`TCDM_DATA_WIDTH/8-1:0] be;
   } dma_req_t;

   // Bank word, seen as two lanes or as one wide value
   // Lane 0 sits in the low half
   typedef union packed {
      logic [1:0][`TCDM_DATA_WIDTH-1:0] lanes;
      logic [`TCDM_WIDE_WIDTH-1:0]      word;
   } tcdm_word_u;

   // **************************************************************************
   // Wide side
   // **************************************************************************

   // Wide channel request with the address already split
   typedef struct packed {
      logic [$clog2(`TCDM_NB_BANKS)-1:0] bank;
      logic [`TCDM_ROW_WIDTH-1:0]        row;
      logic                              wen;
      tcdm_word_u                        wdata;
      logic [`TCDM_WIDE_WIDTH/8-1:0]     be;
   } chan_req_t;

   // What one SRAM bank port sees
   typedef struct packed {
      logic [`TCDM_ROW_WIDTH-1:0]    row;
      logic                          wen;
      tcdm_word_u                    wdata;
      logic [`TCDM_WIDE_WIDTH/8-1:0] be;
   } bank_req_t;

   // One bit per wide channel
   typedef logic [`TCDM_NB_CHAN-1:0] chan_mask_t;

endpackage

`default_nettype wire

// File: design/tcdm_resp_route.sv
// Banks must return rdata exactly one cycle after a granted request, for reads and writes
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

module tcdm_resp_route
(
   input  logic                                        clk_i,
   input  logic                                        reset_i,

   // Per-bank grant masks and read data
   input  tcdm_pkg::chan_mask_t [`TCDM_NB_BANKS-1:0]   bank_gnt_i,
   input  tcdm_pkg::tcdm_word_u [`TCDM_NB_BANKS-1:0]   bank_rdata_i,

   // Responses to the narrow DMA ports
   output logic [`TCDM_NB_DMA_PORTS-1:0]                        dma_gnt_o,
   output logic [`TCDM_NB_DMA_PORTS-1:0]                        dma_r_valid_o,
   output logic [`TCDM_NB_DMA_PORTS-1:0][`TCDM_DATA_WIDTH-1:0]  dma_r_rdata_o
);

   import tcdm_pkg::*;

   localparam int unsigned BANK_W = $clog2(`TCDM_NB_BANKS);

   chan_mask_t                          chan_gnt;
   chan_mask_t                          r_valid_q;
   logic [`TCDM_NB_CHAN-1:0][BANK_W-1:0] bank_sel_d;
   logic [`TCDM_NB_CHAN-1:0][BANK_W-1:0] bank_sel_q;

   // A channel is granted by at most one bank
   // so OR and encode together
   always_comb
   begin
      chan_gnt   = '0;
      bank_sel_d = '0;
      for (int b = 0; b < `TCDM_NB_BANKS; b++)
      begin
         for (int c = 0; c < `TCDM_NB_CHAN; c++)
         begin
            if (bank_gnt_i[b][c])
            begin
               chan_gnt[c]   = 1'b1;
               bank_sel_d[c] = BANK_W'(b);
            end
         end
      end
   end

   // Response tracking, one cycle deep
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         r_valid_q <= '0;
      else
         r_valid_q <= chan_gnt;
   end

   always_ff @(posedge clk_i)
   begin
      bank_sel_q <= bank_sel_d;
   end

   // Fan out to the port pairs
   for (genvar c = 0; c < `TCDM_NB_CHAN; c++)
   begin : g_port_pair
      tcdm_word_u rdata_word;

      assign rdata_word = bank_rdata_i[bank_sel_q[c]];

      assign dma_gnt_o[2*c]       = chan_gnt[c];
      assign dma_gnt_o[2*c+1]     = chan_gnt[c];
      assign dma_r_valid_o[2*c]   = r_valid_q[c];
      assign dma_r_valid_o[2*c+1] = r_valid_q[c];

      // Low lane to the even port
      assign dma_r_rdata_o[2*c]   = rdata_word.lanes[0];
      assign dma_r_rdata_o[2*c+1] = rdata_word.lanes[1];
   end

endmodule

`default_nettype wire

// File: design/tcdm_settings.svh
// Fixed layout of 4 DMA ports in 2 channels and 16 banks of 4096 x 64 bits; address bits above 18 are ignored
`ifndef TCDM_SETTINGS_SVH
`define TCDM_SETTINGS_SVH

// **************************************************************************
// Requester side
// **************************************************************************

// Narrow DMA ports, one 32-bit word each
`define TCDM_NB_DMA_PORTS 4
// Two DMA ports make one wide channel
`define TCDM_NB_CHAN      (`TCDM_NB_DMA_PORTS / 2)

// Byte address width on the DMA side
`define TCDM_ADDR_WIDTH   32
// Width of one DMA lane
`define TCDM_DATA_WIDTH   32

// **************************************************************************
// Memory side
// **************************************************************************

// SRAM banks behind the crossbar
`define TCDM_NB_BANKS     16
// One bank word holds two DMA lanes
`define TCDM_WIDE_WIDTH   64
// Rows per bank as address bits, taken from add[14:3]
`define TCDM_ROW_WIDTH    12
// Bank index starts right above the row, add[18:15]
`define TCDM_BANK_LSB     15

`endif

// File: test/tb_dma_tcdm_xbar.sv
// Stops at the first error; wen high means write, random rows stay low so reads hit written bytes
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

module tb_dma_tcdm_xbar;

   import tcdm_pkg::*;

   localparam int DRV_DLY  = 10;
   localparam int MAX_WAIT = 8;

   logic                                                clk;
   logic                                                reset;
   dma_req_t   [`TCDM_NB_DMA_PORTS-1:0]                 dma_req;
   logic       [`TCDM_NB_DMA_PORTS-1:0]                 dma_valid;
   logic       [`TCDM_NB_DMA_PORTS-1:0]                 dma_gnt;
   logic       [`TCDM_NB_DMA_PORTS-1:0]                 dma_r_valid;
   logic       [`TCDM_NB_DMA_PORTS-1:0][`TCDM_DATA_WIDTH-1:0] dma_r_rdata;
   bank_req_t  [`TCDM_NB_BANKS-1:0]                     bank_req;
   logic       [`TCDM_NB_BANKS-1:0]                     bank_valid;
   tcdm_word_u [`TCDM_NB_BANKS-1:0]                     bank_rdata;

   // Shadow words keyed by bank and row, plus bytes written so far
   logic [63:0] shadow [int];
   logic [7:0]  known  [int];

   // Per channel, set at grant and checked one cycle later
   logic        pend_gnt   [`TCDM_NB_CHAN];
   logic        pend_rd    [`TCDM_NB_CHAN];
   logic [63:0] pend_word  [`TCDM_NB_CHAN];
   logic [7:0]  pend_known [`TCDM_NB_CHAN];

   int w0;
   int w1;

   dma_tcdm_xbar UUT
   (
      .clk_i (clk), .reset_i (reset), .dma_req_i (dma_req), .dma_valid_req_i (dma_valid),
      .dma_gnt_o (dma_gnt), .dma_r_valid_o (dma_r_valid), .dma_r_rdata_o (dma_r_rdata),
      .bank_req_o (bank_req), .bank_valid_o (bank_valid), .bank_rdata_i (bank_rdata)
   );

   tcdm_bank_model bank_model_inst
   (
      .clk_i (clk), .bank_req_i (bank_req), .bank_valid_i (bank_valid),
      .bank_rdata_o (bank_rdata)
   );

   always #50 clk = ~clk;

   // **************************************************************************
   // Error exit and reference model
   // **************************************************************************

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic value_error(input string sig, input logic [63:0] exp, input logic [63:0] got);
      abort_run($sformatf("FAIL at %0t ns: %s expected %h, got %h", $time, sig, exp, got));
   endtask

   // Byte address layout: row in 14..3, bank in 18..15
   function automatic logic [31:0] addr_of(input int bank, input int row);
      return {13'h0, 4'(bank), 12'(row), 3'b000};
   endfunction

   // Applies a write to the shadow, returns the word a read would see
   function automatic logic [63:0] ref_access(input logic [31:0] add, input logic wen,
      input logic [63:0] wdata, input logic [7:0] be, output logic [7:0] known_o);
      int          key;
      logic [63:0] word;
      logic [7:0]  mask;
      key  = int'(add[18:3]);
      word = shadow.exists(key) ? shadow[key] : 64'h0;
      mask = known.exists(key) ? known[key] : 8'h0;
      for (int i = 0; i < 8; i++)
      begin
         if (wen && be[i])
         begin
            word[8*i +: 8] = wdata[8*i +: 8];
            mask[i]        = 1'b1;
         end
      end
      shadow[key] = word;
      known[key]  = mask;
      known_o     = mask;
      return word;
   endfunction

   // **************************************************************************
   // Compare process, sampled mid-cycle
   // **************************************************************************

   always @(negedge clk)
   begin
      logic [31:0] lane_mask;
      int          p;
      if (!reset)
      begin
         for (int c = 0; c < `TCDM_NB_CHAN; c++)
         begin
            // Response to last cycle's grant
            for (int k = 0; k < 2; k++)
            begin
               p = 2*c + k;
               assert (dma_r_valid[p] === pend_gnt[c])
               else value_error($sformatf("dma_r_valid_o[%0d]", p), pend_gnt[c], dma_r_valid[p]);
               if (pend_gnt[c] && pend_rd[c])
               begin
                  for (int i = 0; i < 4; i++)
                     lane_mask[8*i +: 8] = {8{pend_known[c][4*k+i]}};
                  assert ((dma_r_rdata[p] & lane_mask) === (pend_word[c][32*k +: 32] & lane_mask))
                  else value_error($sformatf("dma_r_rdata_o[%0d]", p),
                                   pend_word[c][32*k +: 32] & lane_mask,
                                   dma_r_rdata[p] & lane_mask);
               end
            end
            // Grant must match across the pair and need a request
            assert (dma_gnt[2*c] === dma_gnt[2*c+1] && !(dma_gnt[2*c] && !dma_valid[2*c]))
            else abort_run($sformatf("Channel %0d grant is split or has no request", c));
            pend_gnt[c] = dma_gnt[2*c];
            pend_rd[c]  = !dma_req[2*c].wen;
            if (dma_gnt[2*c])
               pend_word[c] = ref_access(dma_req[2*c].add, dma_req[2*c].wen,
                                         {dma_req[2*c+1].wdata, dma_req[2*c].wdata},
                                         {dma_req[2*c+1].be, dma_req[2*c].be}, pend_known[c]);
         end
      end
   end

   // **************************************************************************
   // Stimulus tasks
   // **************************************************************************

   // Both ports of a pair carry the same add and wen
   task automatic issue(input int c, input logic [31:0] add, input logic wen,
                        input logic [63:0] wdata, input logic [7:0] be, output int waited);
      @(posedge clk);
      #DRV_DLY;
      for (int k = 0; k < 2; k++)
      begin
         dma_req[2*c+k].add   = add;
         dma_req[2*c+k].wen   = wen;
         dma_req[2*c+k].wdata = wdata[32*k +: 32];
         dma_req[2*c+k].be    = be[4*k +: 4];
         dma_valid[2*c+k]     = 1'b1;
      end
      waited = 0;
      @(negedge clk);
      while (!dma_gnt[2*c])
      begin
         waited++;
         if (waited > MAX_WAIT)
            abort_run($sformatf("Timeout: channel %0d never granted", c));
         @(negedge clk);
      end
      @(posedge clk);
      #DRV_DLY;
      dma_valid[2*c +: 2] = 2'b00;
   endtask

   task automatic check_idle(input int cycles);
      for (int i = 0; i < cycles; i++)
      begin
         @(negedge clk);
         assert (dma_r_valid === '0 && bank_valid === '0)
         else abort_run("Response or bank request active with no request pending");
      end
   endtask

   task automatic random_traffic(input int c, input int n);
      logic [31:0] add;
      int          waited;
      for (int i = 0; i < n; i++)
      begin
         add       = addr_of($urandom_range(15), $urandom_range(7));
         // Ignored upper bits and byte offset get noise
         add[31:19] = 13'($urandom);
         add[2:0]   = 3'($urandom);
         issue(c, add, 1'($urandom), {$urandom, $urandom}, 8'($urandom), waited);
      end
   endtask

   // **************************************************************************
   // Test sequence
   // **************************************************************************

   initial
   begin
      void'($urandom(32'h543a91ec));
      clk       = 1'b0;
      reset     = 1'b1;
      dma_req   = '0;
      dma_valid = '0;
      for (int c = 0; c < `TCDM_NB_CHAN; c++)
         pend_gnt[c] = 1'b0;
      repeat (5) @(posedge clk);
      #DRV_DLY;
      reset = 1'b0;
      check_idle(4);

      // Paired write then read, then partial byte write
      issue(0, addr_of(3, 12'h021), 1'b1, 64'hCAFE_0001_1234_5678, 8'hFF, w0);
      issue(0, addr_of(3, 12'h021), 1'b0, 64'h0, 8'h00, w0);
      issue(1, addr_of(3, 12'h021), 1'b1, 64'h1111_2222_3333_4444, 8'b0110_1001, w0);
      issue(1, addr_of(3, 12'h021), 1'b0, 64'h0, 8'h00, w0);

      // Different banks in one cycle
      fork
         issue(0, addr_of(5, 12'h100), 1'b1, 64'hAAAA_0000_BBBB_0000, 8'hFF, w0);
         issue(1, addr_of(9, 12'h200), 1'b1, 64'h0000_CCCC_0000_DDDD, 8'hFF, w1);
      join
      assert (w0 == 0 && w1 == 0)
      else abort_run("Channels on different banks were not granted in the same cycle");

      // Lone channel 0 access leaves the bank 7 pointer on channel 1
      issue(0, addr_of(7, 12'h012), 1'b0, 64'h0, 8'h00, w0);

      // Same bank, writes then reads of two rows
      // Channel 1 goes first each round, channel 0 one cycle later
      for (int r = 0; r < 2; r++)
      begin
         fork
            issue(0, addr_of(7, 12'h010), !r[0], 64'h0101_0202_0303_0404, 8'hFF, w0);
            issue(1, addr_of(7, 12'h011), !r[0], 64'h0505_0606_0707_0808, 8'hFF, w1);
         join
         assert (w1 == 0 && w0 == 1)
         else abort_run("Channels on one bank were not served in round-robin order");
      end

      fork
         random_traffic(0, 300);
         random_traffic(1, 300);
      join
      // Last response is still out for one cycle
      @(posedge clk);
      check_idle(3);
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: test/tcdm_bank_model.sv
// Behavioral SRAM for all banks, not reset; wen high writes, rdata holds the old word one cycle later
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

module tcdm_bank_model
(
   input  logic                                      clk_i,
   input  tcdm_pkg::bank_req_t  [`TCDM_NB_BANKS-1:0] bank_req_i,
   input  logic                 [`TCDM_NB_BANKS-1:0] bank_valid_i,
   output tcdm_pkg::tcdm_word_u [`TCDM_NB_BANKS-1:0] bank_rdata_o
);

   import tcdm_pkg::*;

   logic [`TCDM_WIDE_WIDTH-1:0] mem [`TCDM_NB_BANKS][2**`TCDM_ROW_WIDTH];

   // Fill depends on bank and row, stale reads stand out
   initial
   begin
      logic [15:0] key;
      for (int b = 0; b < `TCDM_NB_BANKS; b++)
      begin
         for (int r = 0; r < 2**`TCDM_ROW_WIDTH; r++)
         begin
            key      = {4'(b), 12'(r)};
            mem[b][r] = {key ^ 16'hA55A, key, ~key, key + 16'hD00D};
         end
      end
   end

   // Read first, then byte-masked write
   always @(posedge clk_i)
   begin
      for (int b = 0; b < `TCDM_NB_BANKS; b++)
      begin
         if (bank_valid_i[b])
         begin
            bank_rdata_o[b].word <= mem[b][bank_req_i[b].row];
            for (int i = 0; i < `TCDM_WIDE_WIDTH/8; i++)
            begin
               if (bank_req_i[b].wen && bank_req_i[b].be[i])
                  mem[b][bank_req_i[b].row][8*i +: 8] <= bank_req_i[b].wdata.word[8*i +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/tcdm_pkg.sv
design/dma_port_merge.sv
design/tcdm_bank_arbiter.sv
design/tcdm_resp_route.sv
design/dma_tcdm_xbar.sv
test/tcdm_bank_model.sv
test/tb_dma_tcdm_xbar.sv
